// ==== build.f ====
src/l2_geom_pkg.sv
src/l2_ctrl_pkg.sv
src/l2_req_buf.sv
src/l2_way.sv
src/l2_way_select.sv
src/l2_main_fsm.sv
src/l2_cache_top.sv
testbench/l2_cache_asserts.sv
testbench/l2_checker.sv
testbench/tb_l2_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the L2 cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_l2_cache \
    -f build.f -Mdir obj_dir -o sim_l2
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_l2 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// ==== testbench/tb_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l2_cache;
    import l2_geom_pkg::*;

    localparam int ways = 4;
    localparam int index_w = 4;
    localparam int num_req = 400;
    localparam int max_cycles = num_req * 20;   // worst case per request

    logic   clk, rstn, req, wr, addr_ok, data_ok;
    addr_t  addr, mem_addr;
    word_t  wdata, rdata;
    logic   mem_req_r, mem_req_w, mem_addr_ok_r, mem_addr_ok_w, mem_rdy, mem_data_ok;
    block_t mem_rdata, mem_wdata;
    integer seed;
    int     cycles = 0;
    int     mismatches, faults;
    block_t mem_blocks [2 ** (ADDR_W - OFFSET_W)];

    l2_cache_top #(.ways(ways), .index_w(index_w)) dut0 (.*);

    l2_checker #(.ways(ways), .index_w(index_w)) check0 (
        .*, .mismatch_count(mismatches), .fault_count(faults)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t pattern_word(addr_t a);
        return {a ^ 16'h9e37, ~a};
    endfunction

    // six tags over four sets, more tags than ways
    function automatic addr_t pick_addr();
        int t;
        int s;
        int o;
        t = {$random(seed)} % 6;
        s = {$random(seed)} % 4;
        o = {$random(seed)} % 2;
        return addr_t'((t * 37 + 3) << (index_w + OFFSET_W)) | addr_t'((s * 5) << OFFSET_W)
               | addr_t'(o);
    endfunction

    task automatic issue(input logic w, input addr_t a, input word_t d);
        req   = 1'b1;
        wr    = w;
        addr  = a;
        wdata = d;
        do @(posedge clk); while (!addr_ok);
        @(negedge clk);
        req = 1'b0;
        wr  = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // requester
    //////////////////////////////////////////////////

    initial begin
        logic w;
        seed  = 39978;
        rstn  = 1'b0;
        req   = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < num_req; i++) begin
            repeat ({$random(seed)} % 3) @(negedge clk);
            w = (i == num_req - 1) ? 1'b0 : 1'($random(seed));   // last one is a read
            issue(w, pick_addr(), $random(seed));
        end
        do @(posedge clk); while (!data_ok);
        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, faults);
        if (mismatches == 0 && faults == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // memory model, 0 to 3 cycles per handshake
    //////////////////////////////////////////////////

    initial begin
        addr_t a;
        for (int i = 0; i < 2 ** (ADDR_W - OFFSET_W); i++)
            mem_blocks[i] = {pattern_word(addr_t'(2 * i + 1)), pattern_word(addr_t'(2 * i))};
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        forever begin
            @(negedge clk);
            if (mem_req_w) begin
                repeat ({$random(seed)} % 4) @(negedge clk);
                mem_addr_ok_w = 1'b1;
                mem_blocks[mem_addr >> OFFSET_W] = mem_wdata;
                @(negedge clk);
                mem_addr_ok_w = 1'b0;
            end else if (mem_req_r) begin
                repeat ({$random(seed)} % 4) @(negedge clk);
                mem_addr_ok_r = 1'b1;
                a = mem_addr;
                @(negedge clk);
                mem_addr_ok_r = 1'b0;
                repeat ({$random(seed)} % 4) @(negedge clk);
                mem_data_ok = 1'b1;
                mem_rdata   = mem_blocks[a >> OFFSET_W];
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

endmodule

// ==== testbench/l2_checker.sv ====
`timescale 1ns/1ps

module l2_checker #(
    parameter int ways = l2_geom_pkg::WAYS_DEFAULT,
    parameter int index_w = l2_geom_pkg::INDEX_W_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req,
    input  logic                 wr,
    input  l2_geom_pkg::addr_t   addr,
    input  l2_geom_pkg::word_t   wdata,
    input  logic                 addr_ok,
    input  logic                 data_ok,
    input  l2_geom_pkg::word_t   rdata,
    input  logic                 mem_req_r,
    input  logic                 mem_req_w,
    input  logic                 mem_addr_ok_r,
    input  logic                 mem_addr_ok_w,
    input  logic                 mem_rdy,
    input  logic                 mem_data_ok,
    input  l2_geom_pkg::addr_t   mem_addr,
    input  l2_geom_pkg::block_t  mem_wdata,
    output int                   mismatch_count,
    output int                   fault_count
);
    import l2_geom_pkg::*;

    localparam int sets = 2 ** index_w;
    localparam int tag_w = ADDR_W - index_w - OFFSET_W;

    logic             m_valid [sets][ways];
    logic             m_dirty [sets][ways];
    logic [tag_w-1:0] m_tag [sets][ways];
    block_t           m_data [sets][ways];
    int               m_ptr [sets];
    block_t           backing [addr_t];   // blocks written back so far

    bit     exp_wb, exp_rd, exp_fill, exp_data, exp_hit_read;
    addr_t  exp_wb_addr, exp_rd_addr;
    block_t exp_wb_data;
    word_t  exp_word;
    int     cyc;
    int     accept_cyc;

    function automatic word_t fresh_word(addr_t a);
        return {a ^ 16'h9e37, ~a};
    endfunction

    function automatic block_t stored_block(addr_t b);
        if (backing.exists(b))
            return backing[b];
        return {fresh_word(b | addr_t'(1)), fresh_word(b)};
    endfunction

    task automatic mismatch(input string name, input logic [63:0] expv, input logic [63:0] gotv);
        $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, expv, gotv);
        mismatch_count++;
    endtask

    task automatic fault(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        fault_count++;
    endtask

    //////////////////////////////////////////////////
    // reference lookup, one call per accepted request
    //////////////////////////////////////////////////

    task automatic model_access(input logic w, input addr_t a, input word_t d);
        int               idx;
        int               off;
        int               way;
        int               free;
        logic [tag_w-1:0] t;
        addr_t            blk;
        bit               hit_now;

        idx     = a[OFFSET_W +: index_w];
        off     = a[OFFSET_W-1:0];
        t       = a[ADDR_W-1 -: tag_w];
        blk     = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        hit_now = 0;
        way     = 0;
        free    = -1;
        for (int i = ways - 1; i >= 0; i--) begin
            if (m_valid[idx][i] && m_tag[idx][i] == t) begin
                hit_now = 1;
                way     = i;
            end
            if (!m_valid[idx][i])
                free = i;
        end
        if (!hit_now) begin
            if (free >= 0) begin
                way = free;
            end else begin
                way         = m_ptr[idx];   // round robin
                m_ptr[idx]  = (m_ptr[idx] + 1) % ways;
            end
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                exp_wb      = 1;
                exp_wb_addr = {m_tag[idx][way], idx[index_w-1:0], {OFFSET_W{1'b0}}};
                exp_wb_data = m_data[idx][way];
                backing[exp_wb_addr] = m_data[idx][way];
            end
            exp_rd            = 1;
            exp_rd_addr       = blk;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way]   = t;
            m_data[idx][way]  = stored_block(blk);
        end
        if (w) begin
            m_data[idx][way][off*WORD_W +: WORD_W] = d;
            m_dirty[idx][way] = 1'b1;
        end else begin
            exp_data     = 1;
            exp_hit_read = hit_now;
            exp_word     = m_data[idx][way][off*WORD_W +: WORD_W];
        end
    endtask

    //////////////////////////////////////////////////
    // port monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            mismatch_count = 0;
            fault_count    = 0;
            cyc            = 0;
            accept_cyc     = 0;
            exp_wb         = 0;
            exp_rd         = 0;
            exp_fill       = 0;
            exp_data       = 0;
            exp_hit_read   = 0;
            for (int s = 0; s < sets; s++) begin
                m_ptr[s] = 0;
                for (int w = 0; w < ways; w++) begin
                    m_valid[s][w] = 1'b0;
                    m_dirty[s][w] = 1'b0;
                end
            end
        end else begin
            cyc++;
            if (addr_ok && !req)
                fault("addr_ok while no request was pending");
            if (mem_req_r && mem_req_w)
                fault("memory read and write requests overlap");
            if (mem_req_w && !exp_wb)
                fault("memory write request without a dirty victim");
            if (mem_req_r && !exp_rd)
                fault("memory read request with no miss pending");
            if (mem_rdy && !exp_fill)
                fault("mem_rdy with no refill outstanding");
            if (exp_fill && !mem_rdy)
                fault("mem_rdy low while the refill data is outstanding");
            if (data_ok && !exp_data)
                fault("data_ok with no read pending");

            if (mem_data_ok && exp_fill)
                exp_fill = 0;   // block delivered

            if (mem_req_w && mem_addr_ok_w && exp_wb) begin
                if (mem_addr !== exp_wb_addr)
                    mismatch("mem_addr", 64'(exp_wb_addr), 64'(mem_addr));
                if (mem_wdata !== exp_wb_data)
                    mismatch("mem_wdata", exp_wb_data, mem_wdata);
                exp_wb = 0;
            end
            if (mem_req_r && mem_addr_ok_r && exp_rd) begin
                if (exp_wb)
                    fault("refill requested before the dirty victim was written back");
                if (mem_addr !== exp_rd_addr)
                    mismatch("mem_addr", 64'(exp_rd_addr), 64'(mem_addr));
                exp_rd   = 0;
                exp_fill = 1;
            end

            // hit read answers one cycle after accept
            if (exp_data && exp_hit_read && cyc == accept_cyc + 1 && !data_ok)
                fault("read hit did not return data one cycle after addr_ok");
            if (data_ok && exp_data) begin
                if (exp_wb || exp_rd)
                    fault("read data returned before the miss was served");
                if (rdata !== exp_word)
                    mismatch("rdata", 64'(exp_word), 64'(rdata));
                exp_data = 0;
            end

            if (addr_ok && req) begin
                if (exp_wb || exp_rd || exp_fill || exp_data)
                    fault("request accepted before the previous one finished");
                exp_wb   = 0;
                exp_rd   = 0;
                exp_fill = 0;
                exp_data = 0;
                model_access(wr, addr, wdata);
                accept_cyc = cyc;
            end
        end
    end

endmodule

// ==== testbench/l2_cache_asserts.sv ====
`timescale 1ns/1ps

module l2_cache_asserts (
    input logic clk,
    input logic rstn,
    input logic mem_req_r,
    input logic mem_req_w,
    input logic mem_addr_ok_r,
    input logic mem_addr_ok_w,
    input logic mem_rdy,
    input logic mem_data_ok
);

    // requests stay up until memory takes the address
    a_hold_req_r: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_r && !mem_addr_ok_r |=> mem_req_r)
        else $error("mem_req_r dropped before mem_addr_ok_r");

    a_hold_req_w: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_w && !mem_addr_ok_w |=> mem_req_w)
        else $error("mem_req_w dropped before mem_addr_ok_w");

    a_hold_rdy: assert property (@(posedge clk) disable iff (!rstn)
        mem_rdy && !mem_data_ok |=> mem_rdy)
        else $error("mem_rdy dropped before mem_data_ok");

    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_r && mem_req_w))
        else $error("memory read and write requests high together");

    // data phase opens right after the read address is taken
    a_rdy_after_accept: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_r && mem_addr_ok_r |=> mem_rdy)
        else $error("mem_rdy not raised after mem_addr_ok_r");

endmodule

bind l2_main_fsm l2_cache_asserts u_asserts (.*);

// ==== src/l2_cache_top.sv ====
`timescale 1ns/1ps

module l2_cache_top #(
    parameter int ways = l2_geom_pkg::WAYS_DEFAULT,
    parameter int index_w = l2_geom_pkg::INDEX_W_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rstn,
    // requester
    input  logic                 req,
    input  logic                 wr,
    input  l2_geom_pkg::addr_t   addr,
    input  l2_geom_pkg::word_t   wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output l2_geom_pkg::word_t   rdata,
    // memory
    output logic                 mem_req_r,
    output logic                 mem_req_w,
    input  logic                 mem_addr_ok_r,
    input  logic                 mem_addr_ok_w,
    output logic                 mem_rdy,
    input  logic                 mem_data_ok,
    input  l2_geom_pkg::block_t  mem_rdata,
    output l2_geom_pkg::addr_t   mem_addr,
    output l2_geom_pkg::block_t  mem_wdata
);
    import l2_geom_pkg::*;

    localparam int tag_w = ADDR_W - index_w - OFFSET_W;
    localparam int way_w = $clog2(ways);

    logic                       capture, victim_capture, refill, refill_done;
    logic                       req_wr, hit, victim_dirty, dirty_set;
    logic [index_w-1:0]         index;
    logic [tag_w-1:0]           tag, victim_tag;
    logic [OFFSET_W-1:0]        offset;
    logic [way_w-1:0]           hit_way, victim_way;
    logic [ways-1:0]            hit_vec, valid_vec, dirty_vec;
    logic [ways-1:0]            line_we_vec, dirty_we_vec;
    logic [ways-1:0][tag_w-1:0] rtag_vec;
    block_t [ways-1:0]          rdata_vec;
    block_t                     line_wdata, hit_block, rd_block;

    l2_req_buf #(.index_w(index_w)) u_req_buf (
        .clk(clk), .rstn(rstn), .capture(capture), .wr(wr), .addr(addr), .wdata(wdata),
        .mem_rdata(mem_rdata), .victim_tag(victim_tag), .line_block(hit_block),
        .refill(refill), .mem_req_w(mem_req_w), .req_wr(req_wr), .index(index),
        .tag(tag), .offset(offset), .line_wdata(line_wdata), .mem_addr(mem_addr)
    );

    //////////////////////////////////////////////////
    // ways
    //////////////////////////////////////////////////

    for (genvar g = 0; g < ways; g++) begin : g_way
        l2_way #(.index_w(index_w)) u_way (
            .clk(clk), .rstn(rstn), .index(index), .tag(tag),
            .line_we(line_we_vec[g]), .dirty_we(dirty_we_vec[g]), .dirty_set(dirty_set),
            .line_wdata(line_wdata), .hit(hit_vec[g]), .valid(valid_vec[g]),
            .dirty(dirty_vec[g]), .rtag(rtag_vec[g]), .rdata(rdata_vec[g])
        );
    end

    l2_way_select #(.ways(ways), .index_w(index_w)) u_way_select (
        .clk(clk), .rstn(rstn), .index(index), .hit_vec(hit_vec), .valid_vec(valid_vec),
        .dirty_vec(dirty_vec), .rtag_vec(rtag_vec), .rdata_vec(rdata_vec),
        .victim_capture(victim_capture), .refill_done(refill_done), .hit(hit),
        .hit_way(hit_way), .victim_way(victim_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_block(mem_wdata), .hit_block(hit_block)
    );

    l2_main_fsm #(.ways(ways)) u_main_fsm (
        .clk(clk), .rstn(rstn), .req(req), .hit(hit), .victim_dirty(victim_dirty),
        .mem_addr_ok_r(mem_addr_ok_r), .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok(mem_data_ok), .req_wr(req_wr), .hit_way(hit_way),
        .victim_way(victim_way), .addr_ok(addr_ok), .data_ok(data_ok), .capture(capture),
        .victim_capture(victim_capture), .refill_done(refill_done), .refill(refill),
        .mem_req_r(mem_req_r), .mem_req_w(mem_req_w), .mem_rdy(mem_rdy),
        .line_we_vec(line_we_vec), .dirty_we_vec(dirty_we_vec), .dirty_set(dirty_set)
    );

    // read word straight from memory on a refill
    assign rd_block = refill ? mem_rdata : hit_block;
    assign rdata    = rd_block[offset*WORD_W +: WORD_W];

endmodule

// ==== src/l2_main_fsm.sv ====
`timescale 1ns/1ps

module l2_main_fsm #(
    parameter int ways = l2_geom_pkg::WAYS_DEFAULT,
    localparam int way_w = $clog2(ways)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req,
    input  logic              hit,
    input  logic              victim_dirty,
    input  logic              mem_addr_ok_r,
    input  logic              mem_addr_ok_w,
    input  logic              mem_data_ok,
    input  logic              req_wr,
    input  logic [way_w-1:0]  hit_way,
    input  logic [way_w-1:0]  victim_way,
    output logic              addr_ok,
    output logic              data_ok,
    output logic              capture,
    output logic              victim_capture,
    output logic              refill_done,
    output logic              refill,
    output logic              mem_req_r,
    output logic              mem_req_w,
    output logic              mem_rdy,
    output logic [ways-1:0]   line_we_vec,
    output logic [ways-1:0]   dirty_we_vec,
    output logic              dirty_set
);
    import l2_ctrl_pkg::*;

    l2_state_e state;
    l2_state_e next_state;

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= s_idle;
        else
            state <= next_state;
    end

    //////////////////////////////////////////////////
    // next state and strobes
    //////////////////////////////////////////////////

    always_comb begin
        next_state     = state;
        addr_ok        = 1'b0;
        data_ok        = 1'b0;
        capture        = 1'b0;
        victim_capture = 1'b0;
        refill_done    = 1'b0;
        refill         = 1'b0;
        mem_req_r      = 1'b0;
        mem_req_w      = 1'b0;
        mem_rdy        = 1'b0;
        line_we_vec    = '0;
        dirty_we_vec   = '0;
        dirty_set      = 1'b0;

        case (state)
            s_idle: begin
                if (req) begin
                    addr_ok    = 1'b1;   // request taken this cycle
                    capture    = 1'b1;
                    next_state = s_lookup;
                end
            end

            s_lookup: begin
                if (hit) begin
                    if (req_wr == kind_write) begin
                        // merged line back into the hit way, mark dirty
                        line_we_vec[hit_way]  = 1'b1;
                        dirty_we_vec[hit_way] = 1'b1;
                        dirty_set             = 1'b1;
                    end else begin
                        data_ok = 1'b1;
                    end
                    next_state = s_idle;
                end else begin
                    next_state = s_check_dirty;
                end
            end

            s_check_dirty: begin
                victim_capture = 1'b1;
                next_state     = victim_dirty ? s_writeback : s_refill_req;
            end

            s_writeback: begin
                mem_req_w = 1'b1;   // held until accepted
                if (mem_addr_ok_w)
                    next_state = s_refill_req;
            end

            s_refill_req: begin
                mem_req_r = 1'b1;
                if (mem_addr_ok_r)
                    next_state = s_refill_wait;
            end

            s_refill_wait: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    refill                   = 1'b1;
                    refill_done              = 1'b1;
                    line_we_vec[victim_way]  = 1'b1;
                    dirty_we_vec[victim_way] = 1'b1;   // fresh line is clean
                    if (req_wr == kind_read) begin
                        data_ok    = 1'b1;
                        next_state = s_idle;
                    end else begin
                        next_state = s_merge_write;
                    end
                end
            end

            s_merge_write: begin
                // refilled line now hits, store word goes on top
                line_we_vec[victim_way]  = 1'b1;
                dirty_we_vec[victim_way] = 1'b1;
                dirty_set                = 1'b1;
                next_state               = s_idle;
            end

            default: next_state = s_idle;
        endcase
    end

endmodule

// ==== src/l2_way_select.sv ====
`timescale 1ns/1ps

module l2_way_select #(
    parameter int ways = l2_geom_pkg::WAYS_DEFAULT,
    parameter int index_w = l2_geom_pkg::INDEX_W_DEFAULT,
    localparam int tag_w = l2_geom_pkg::ADDR_W - index_w - l2_geom_pkg::OFFSET_W,
    localparam int way_w = $clog2(ways)
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [index_w-1:0]                 index,
    input  logic [ways-1:0]                    hit_vec,
    input  logic [ways-1:0]                    valid_vec,
    input  logic [ways-1:0]                    dirty_vec,
    input  logic [ways-1:0][tag_w-1:0]         rtag_vec,
    input  l2_geom_pkg::block_t [ways-1:0]     rdata_vec,
    input  logic                               victim_capture,
    input  logic                               refill_done,
    output logic                               hit,
    output logic [way_w-1:0]                   hit_way,
    output logic [way_w-1:0]                   victim_way,
    output logic                               victim_dirty,
    output logic [tag_w-1:0]                   victim_tag,
    output l2_geom_pkg::block_t                victim_block,
    output l2_geom_pkg::block_t                hit_block
);
    localparam int sets = 2 ** index_w;

    logic [way_w-1:0] rr_ptr [sets];
    logic [way_w-1:0] free_way;
    logic [way_w-1:0] pick_way;
    logic             any_free;
    logic             from_ptr_q;   // victim came from the pointer

    // lowest hitting way, lowest invalid way
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int i = ways - 1; i >= 0; i--) begin
            if (hit_vec[i])
                hit_way = way_w'(i);
            if (!valid_vec[i])
                free_way = way_w'(i);
        end
    end

    assign hit       = |hit_vec;
    assign hit_block = rdata_vec[hit_way];

    assign any_free     = ~&valid_vec;
    assign pick_way     = any_free ? free_way : rr_ptr[index];
    assign victim_dirty = valid_vec[pick_way] & dirty_vec[pick_way];   // read in check_dirty

    always_ff @(posedge clk) begin
        if (victim_capture) begin
            victim_way   <= pick_way;
            victim_tag   <= rtag_vec[pick_way];
            victim_block <= rdata_vec[pick_way];
        end
    end

    // per-set round robin, steps once per refill
    always_ff @(posedge clk) begin
        if (!rstn) begin
            from_ptr_q <= 1'b0;
            for (int s = 0; s < sets; s++)
                rr_ptr[s] <= '0;
        end else begin
            if (victim_capture)
                from_ptr_q <= ~any_free;
            if (refill_done && from_ptr_q)
                rr_ptr[index] <= way_w'(rr_ptr[index] + 1'b1);
        end
    end

endmodule

// ==== src/l2_way.sv ====
`timescale 1ns/1ps

module l2_way #(
    parameter int index_w = l2_geom_pkg::INDEX_W_DEFAULT,
    localparam int tag_w = l2_geom_pkg::ADDR_W - index_w - l2_geom_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [index_w-1:0]   index,
    input  logic [tag_w-1:0]     tag,
    input  logic                 line_we,
    input  logic                 dirty_we,
    input  logic                 dirty_set,
    input  l2_geom_pkg::block_t  line_wdata,
    output logic                 hit,
    output logic                 valid,
    output logic                 dirty,
    output logic [tag_w-1:0]     rtag,
    output l2_geom_pkg::block_t  rdata
);
    import l2_geom_pkg::*;

    localparam int sets = 2 ** index_w;

    logic [tag_w-1:0] tag_mem [sets];
    block_t           data_mem [sets];
    logic [sets-1:0]  valid_q;
    logic [sets-1:0]  dirty_q;

    //////////////////////////////////////////////////
    // array writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (line_we)
                valid_q[index] <= 1'b1;
            if (dirty_we)
                dirty_q[index] <= dirty_set;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= line_wdata;
        end
    end

    //////////////////////////////////////////////////
    // combinational read and compare
    //////////////////////////////////////////////////

    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign rtag  = tag_mem[index];
    assign rdata = data_mem[index];
    assign hit   = valid && (rtag == tag);

endmodule

// ==== src/l2_req_buf.sv ====
`timescale 1ns/1ps

module l2_req_buf #(
    parameter int index_w = l2_geom_pkg::INDEX_W_DEFAULT,
    localparam int tag_w = l2_geom_pkg::ADDR_W - index_w - l2_geom_pkg::OFFSET_W
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               capture,
    input  logic                               wr,
    input  l2_geom_pkg::addr_t                 addr,
    input  l2_geom_pkg::word_t                 wdata,
    input  l2_geom_pkg::block_t                mem_rdata,
    input  logic [tag_w-1:0]                   victim_tag,
    input  l2_geom_pkg::block_t                line_block,
    input  logic                               refill,
    input  logic                               mem_req_w,
    output logic                               req_wr,
    output logic [index_w-1:0]                 index,
    output logic [tag_w-1:0]                   tag,
    output logic [l2_geom_pkg::OFFSET_W-1:0]   offset,
    output l2_geom_pkg::block_t                line_wdata,
    output l2_geom_pkg::addr_t                 mem_addr
);
    import l2_geom_pkg::*;

    word_t  wdata_q;
    block_t merged;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_wr <= 1'b0;
            index  <= '0;
        end else if (capture) begin
            req_wr <= wr;
            index  <= addr[OFFSET_W +: index_w];
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            tag     <= addr[ADDR_W-1 -: tag_w];
            offset  <= addr[OFFSET_W-1:0];
            wdata_q <= wdata;
        end
    end

    // store word dropped into the current line
    always_comb begin
        merged = line_block;
        merged[offset*WORD_W +: WORD_W] = wdata_q;
    end

    assign line_wdata = refill ? mem_rdata : merged;

    // victim address only while the write-back is requested
    assign mem_addr = mem_req_w ? {victim_tag, index, {OFFSET_W{1'b0}}}
                                : {tag, index, {OFFSET_W{1'b0}}};

endmodule

// ==== src/l2_ctrl_pkg.sv ====
package l2_ctrl_pkg;

    // main controller states, miss path runs top to bottom
    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_check_dirty,
        s_writeback,
        s_refill_req,
        s_refill_wait,
        s_merge_write
    } l2_state_e;

    // meaning of the wr bit of a request
    typedef enum logic {
        kind_read  = 1'b0,
        kind_write = 1'b1
    } l2_kind_e;

endpackage

// ==== src/l2_geom_pkg.sv ====
package l2_geom_pkg;

    //////////////////////////////////////////////////
    // address and data geometry
    //////////////////////////////////////////////////

    localparam int ADDR_W = 16;       // word address
    localparam int WORD_W = 32;

    // two words per block, lowest address bit picks the word
    localparam int BLOCK_WORDS = 2;
    localparam int OFFSET_W = $clog2(BLOCK_WORDS);
    localparam int BLOCK_W = WORD_W * BLOCK_WORDS;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BLOCK_W-1:0] block_t;

    //////////////////////////////////////////////////
    // default cache shape
    //////////////////////////////////////////////////

    localparam int WAYS_DEFAULT = 4;
    localparam int INDEX_W_DEFAULT = 4;   // 16 sets

endpackage
